//--- Makefile
# Verilator simulation of the music box
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into sim.log, check for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module musicBoxTb \
		-f vlog.f --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/VmusicBoxTb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(BUILD_DIR) sim.log

//--- dv/musicBoxTb.sv
//--------------------------------------------------------------------------
// Music box testbench
// Clock, reset, key and Arduino SPI stimulus, DAC word capture,
// tone and display checks, watchdog and the closing summary
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module musicBoxTb;

	localparam int SAMPLE_DIVIDE   = 40;
	localparam int WORD_CYCLES     = SAMPLE_DIVIDE;   // One DAC word per sample tick
	localparam int FRAME_CYCLES    = 4 + 24 * 8 + 4 + 10;
	localparam int KEY_CODE        = 128 * 16;        // Key level scaled to 12 bits
	localparam int FULL_CODE       = 255 * 16;        // Clipped mix
	localparam int TOTAL_WORDS     = 20 + 60 + 5 * 61 + 200 + 2 * 49 + 60 + 7 * 3;
	localparam int TEST_CYCLES     = 8 + 7 * FRAME_CYCLES + 4 * 30 + TOTAL_WORDS * WORD_CYCLES;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES * 3 / 2;

	localparam int NOTE_TICKS [6] = '{61, 54, 49, 46, 41, 36}; // Notes C to A
	// gfedcba, active low, hex 0 to F
	localparam logic [6:0] HEX_SEGMENTS [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	logic                                              clock50Mhz;
	logic                                              reset;
	logic [audioPkg::KEY_COUNT-1:0]                    musicKeys;
	logic                                              spiSclk;
	logic                                              spiCsN;
	logic                                              spiSdo;
	logic                                              dacSclk;
	logic                                              dacSyncN;
	logic                                              dacDin;
	boardIoPkg::segmentT [boardIoPkg::DIGIT_COUNT-1:0] segments;

	int          seed = 76;
	int          mismatchCount = 0;
	int          failureCount = 0;
	int          wordCount = 0;      // Complete DAC words seen
	int          bitsSeen = 0;
	logic        prevSclk = 1'b0;
	logic [15:0] dacWord;
	logic        collecting;         // Store codes into the queue
	int          codes [$];
	logic [15:0] halfPeriod;
	logic [7:0]  level;
	int          key;

	musicBoxTop #(
		.SAMPLE_DIVIDE   (SAMPLE_DIVIDE),
		.DEBOUNCE_DIVIDE (4),
		.DEBOUNCE_COUNT  (3),
		.SCLK_DIVIDE     (1)
	) DUT (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.musicKeys  (musicKeys),
		.spiSclk    (spiSclk),
		.spiCsN     (spiCsN),
		.spiSdo     (spiSdo),
		.dacSclk    (dacSclk),
		.dacSyncN   (dacSyncN),
		.dacDin     (dacDin),
		.segments   (segments)
	);

	initial clock50Mhz = 1'b0;
	always #5 clock50Mhz = ~clock50Mhz;

	// ----------------------------------------------------------------------
	// DAC capture, bit taken on each dacSclk fall inside a word
	// ----------------------------------------------------------------------
	always @(negedge clock50Mhz) begin
		if (reset || dacSyncN) begin
			if (!reset && bitsSeen != 0) begin
				failureCount++;
				$display("DAC word at %0t ended after only %0d bits", $time, bitsSeen);
			end
			bitsSeen = 0;
		end else if (prevSclk && !dacSclk) begin
			dacWord = {dacWord[14:0], dacDin}; // MSB first
			bitsSeen++;
			if (bitsSeen == 16) begin
				assert (dacWord[15:12] == 4'h0) else begin
					mismatchCount++;
					$display("mismatch at %0t: dacDin control bits expected 0 got %h",
						$time, dacWord[15:12]);
				end
				if (collecting) codes.push_back(int'(dacWord[11:0]));
				wordCount++;
				bitsSeen = 0;
			end
		end
		prevSclk = dacSclk;
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock50Mhz);
		#1; // Drive just after the edge
	endtask

	task automatic waitWords(input int n);
		int target;
		target = wordCount + n;
		while (wordCount < target) @(posedge clock50Mhz);
		#1;
	endtask

	task automatic collectWords(input int n);
		codes.delete();
		collecting = 1'b1;
		waitWords(n);
		collecting = 1'b0;
	endtask

	// Bit-banged Arduino frame, 4 clocks per SCLK half period
	task automatic sendFrame(input logic [23:0] frame, input int bitTotal);
		spiCsN = 1'b0;
		waitCycles(4);
		for (int i = 0; i < bitTotal; i++) begin
			spiSdo  = frame[23 - i];
			spiSclk = 1'b0;
			waitCycles(4);
			spiSclk = 1'b1; // Receiver takes the bit here
			waitCycles(4);
		end
		spiSclk = 1'b0;
		waitCycles(4);
		spiCsN = 1'b1;
		waitCycles(10); // Sync, edge detect, load
	endtask

	task automatic loadRemote(input logic [15:0] ticks, input logic [7:0] height);
		sendFrame({ticks, height}, 24);
		waitWords(3); // Flush words built from the old tone
	endtask

	task automatic checkSegments(input logic [15:0] value);
		for (int i = 0; i < 4; i++) begin
			assert (segments[i] == HEX_SEGMENTS[value[4*i +: 4]]) else begin
				mismatchCount++;
				$display("mismatch at %0t: segments[%0d] expected %h got %h",
					$time, i, HEX_SEGMENTS[value[4*i +: 4]], segments[i]);
			end
		end
	endtask

	task automatic checkSilent(input string label);
		foreach (codes[i]) begin
			assert (codes[i] == 0) else begin
				mismatchCount++;
				$display("mismatch at %0t: dacCode (%s) expected 0 got %0d",
					$time, label, codes[i]);
			end
		end
	endtask

	// Square wave of 0 and highCode, every inner run ticks words long
	task automatic checkTone(input int highCode, input int ticks, input string label);
		int  runLength;
		int  edges;
		bit  sawHigh;
		bit  sawLow;
		runLength = 0;
		edges     = 0;
		sawHigh   = 1'b0;
		sawLow    = 1'b0;
		for (int i = 0; i < codes.size(); i++) begin
			assert (codes[i] == 0 || codes[i] == highCode) else begin
				mismatchCount++;
				$display("mismatch at %0t: dacCode (%s) expected 0 or %0d got %0d",
					$time, label, highCode, codes[i]);
			end
			if (codes[i] == highCode) sawHigh = 1'b1;
			if (codes[i] == 0) sawLow = 1'b1;
			if (i > 0 && codes[i] != codes[i-1]) begin
				// First run starts before the window
				if (edges > 0) begin
					assert (runLength == ticks) else begin
						mismatchCount++;
						$display("mismatch at %0t: run length (%s) expected %0d got %0d",
							$time, label, ticks, runLength);
					end
				end
				edges++;
				runLength = 0;
			end
			runLength++;
		end
		if (!sawHigh || !sawLow || edges < 2) begin
			failureCount++;
			$display("The %s tone never showed both levels in full runs", label);
		end
	endtask

	task automatic checkSaturation();
		bit sawFull;
		sawFull = 1'b0;
		foreach (codes[i]) begin
			assert (codes[i] inside {0, KEY_CODE, 200 * 16, FULL_CODE}) else begin
				mismatchCount++;
				$display("mismatch at %0t: dacCode expected at most %0d got %0d",
					$time, FULL_CODE, codes[i]);
			end
			if (codes[i] == FULL_CODE) sawFull = 1'b1;
		end
		if (!sawFull) begin
			failureCount++;
			$display("The clipped code %0d never appeared", FULL_CODE);
		end
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		reset      = 1'b1;
		musicKeys  = '0;
		spiSclk    = 1'b0;
		spiCsN     = 1'b1;
		spiSdo     = 1'b0;
		collecting = 1'b0;
		waitCycles(8);
		reset = 1'b0;

		waitCycles(2); // Idle state
		checkSegments(16'h0000);
		collectWords(20);
		checkSilent("idle");

		halfPeriod = 16'(2 + {$random(seed)} % 19); // Remote tone alone
		level      = 8'(1 + {$random(seed)} % 255);
		loadRemote(halfPeriod, level);
		checkSegments(halfPeriod);
		collectWords(60);
		checkTone(int'(level) * 16, int'(halfPeriod), "remote");

		key = {$random(seed)} % 6; // Key tone, random higher keys also held
		loadRemote(halfPeriod, 8'd0);
		musicKeys = ((6'($random(seed)) << 1) | 6'd1) << key;
		waitCycles(30);
		waitWords(2);
		collectWords(5 * NOTE_TICKS[key]);
		checkTone(KEY_CODE, NOTE_TICKS[key], "key");

		loadRemote(halfPeriod, 8'd200); // Both tones high clip at 255
		collectWords(200);
		checkSaturation();

		musicKeys = '0; // Short glitch on a key
		loadRemote(halfPeriod, 8'd0);
		musicKeys = 6'b000100;
		waitCycles(3);
		musicKeys = '0;
		collectWords(2 * NOTE_TICKS[2]); // Long enough for a latched key to sound
		checkSilent("key pulse");

		halfPeriod = 16'(2 + {$random(seed)} % 19); // 23 bit frame is ignored
		level      = 8'(1 + {$random(seed)} % 255);
		loadRemote(halfPeriod, level);
		checkSegments(halfPeriod);
		sendFrame({~halfPeriod, ~level}, 23);
		checkSegments(halfPeriod);
		collectWords(60);
		checkTone(int'(level) * 16, int'(halfPeriod), "remote after short frame");

		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		failureCount++;
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- dv/musicBox_sva.sv
//--------------------------------------------------------------------------
// DAC and display port assertions
// SCLK idle level, SYNC word length, state after reset
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module musicBoxSva #(
	parameter int SCLK_DIVIDE = 2
) (
	input logic                                              clock50Mhz,
	input logic                                              reset,
	input logic                                              dacSclk,
	input logic                                              dacSyncN,
	input logic                                              dacDin,
	input boardIoPkg::segmentT [boardIoPkg::DIGIT_COUNT-1:0] segments
);

	// Two SCLK halves per bit
	localparam int WORD_CYCLES = 2 * boardIoPkg::DAC_FRAME_BITS * SCLK_DIVIDE;

	int lowRun; // Cycles dacSyncN has been low

	always_ff @(posedge clock50Mhz) begin
		if (reset || dacSyncN) begin
			lowRun <= 0;
		end else begin
			lowRun <= lowRun + 1;
		end
	end

	sclkIdle: assert property (@(posedge clock50Mhz) disable iff (reset)
		dacSyncN |-> !dacSclk)
		else $error("dacSclk high outside a DAC word");

	syncLength: assert property (@(posedge clock50Mhz) disable iff (reset)
		$rose(dacSyncN) |-> lowRun == WORD_CYCLES)
		else $error("dacSyncN low for %0d cycles instead of %0d", lowRun, WORD_CYCLES);

	syncNotLong: assert property (@(posedge clock50Mhz) disable iff (reset)
		!dacSyncN |-> lowRun < WORD_CYCLES)
		else $error("dacSyncN stayed low past one word");

	// Idle pins and 0000 on the display after reset
	resetIdle: assert property (@(posedge clock50Mhz)
		reset |=> dacSyncN && !dacSclk && !dacDin)
		else $error("DAC pins not idle after reset");

	resetDisplay: assert property (@(posedge clock50Mhz)
		reset |=> segments == {boardIoPkg::DIGIT_COUNT{7'h40}})
		else $error("Display not showing 0000 after reset");

endmodule

bind musicBoxTop musicBoxSva #(.SCLK_DIVIDE(SCLK_DIVIDE)) portChecks (
	.clock50Mhz (clock50Mhz),
	.reset      (reset),
	.dacSclk    (dacSclk),
	.dacSyncN   (dacSyncN),
	.dacDin     (dacDin),
	.segments   (segments)
);

//--- source/arduinoSpiReceiver.sv
//--------------------------------------------------------------------------
// Arduino SPI slave
// Oversamples the three SPI pins and holds the remote tone half period
// and level, loaded only from a frame of exactly 24 bits
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module arduinoSpiReceiver (
	input  logic                 clock50Mhz,
	input  logic                 reset,
	input  logic                 spiSclk,
	input  logic                 spiCsN,
	input  logic                 spiSdo,
	output audioPkg::halfPeriodT remoteHalfPeriod,
	output audioPkg::sampleT     remoteLevel
);

	localparam int FRAME_BITS  = boardIoPkg::SPI_FRAME_BITS;
	localparam int COUNT_WIDTH = $clog2(FRAME_BITS + 1);
	localparam int HALF_BITS   = $bits(audioPkg::halfPeriodT);
	localparam int LEVEL_BITS  = $bits(audioPkg::sampleT);

	logic [2:0]             sclkSync;   // Two sync stages plus edge history
	logic [2:0]             csSync;
	logic [1:0]             sdoSync;
	logic                   sclkRise;   // Registered edge pulses
	logic                   csFall;
	logic                   csRise;
	logic                   sdoBit;     // Data aligned with sclkRise
	logic [FRAME_BITS-1:0]  frameShift;
	logic [COUNT_WIDTH-1:0] bitCount;   // Rising edges since CS fell, saturates

	// ----------------------------------------------------------------------
	// Pin synchronizers and edge detect
	// ----------------------------------------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			sclkSync <= '0;
			csSync   <= '1; // Idle deselected, no false edge out of reset
			sdoSync  <= '0;
			sclkRise <= 1'b0;
			csFall   <= 1'b0;
			csRise   <= 1'b0;
		end else begin
			sclkSync <= {sclkSync[1:0], spiSclk};
			csSync   <= {csSync[1:0], spiCsN};
			sdoSync  <= {sdoSync[0], spiSdo};
			sclkRise <= sclkSync[1] & ~sclkSync[2];
			csFall   <= ~csSync[1] & csSync[2];
			csRise   <= csSync[1] & ~csSync[2];
		end
	end

	// Frame shift register, MSB first
	always_ff @(posedge clock50Mhz) begin
		sdoBit <= sdoSync[1];
		if (sclkRise) begin
			frameShift <= {frameShift[FRAME_BITS-2:0], sdoBit};
		end
	end

	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			bitCount         <= '0;
			remoteHalfPeriod <= '0;
			remoteLevel      <= '0;
		end else begin
			if (csFall) begin
				bitCount <= '0; // New frame
			end else if (sclkRise && bitCount != '1) begin
				bitCount <= bitCount + 1'b1;
			end
			if (csRise && bitCount == COUNT_WIDTH'(FRAME_BITS)) begin
				remoteHalfPeriod <= frameShift[FRAME_BITS-1 -: HALF_BITS];
				remoteLevel      <= frameShift[LEVEL_BITS-1:0];
			end
		end
	end

endmodule

//--- source/audioPkg.sv
//--------------------------------------------------------------------------
// Audio path definitions
// Sample, half period and DAC code types, the key note table
// and the constants of the tone mixer
//--------------------------------------------------------------------------

package audioPkg;

	typedef logic [7:0]  sampleT;     // One audio level
	typedef logic [15:0] halfPeriodT; // Sample ticks per half wave, 0 is silent
	typedef logic [11:0] dacCodeT;    // Code sent to the DAC

	localparam int KEY_COUNT = 6; // Music keys on the panel

	localparam sampleT KEY_LEVEL = 8'd128; // Square wave height of the key tone

	// Notes C to A at a 32 kHz sample rate, key 0 first
	localparam halfPeriodT NOTE_HALF_PERIOD [KEY_COUNT] = '{
		16'd61,
		16'd54,
		16'd49,
		16'd46,
		16'd41,
		16'd36
	};

	localparam int DAC_SHIFT = 4; // 8 bit mix up to 12 bit code, x16

endpackage

//--- source/boardIoPkg.sv
//--------------------------------------------------------------------------
// Board pin definitions
// SPI frame lengths for the Arduino and the DAC, seven segment patterns
//--------------------------------------------------------------------------

package boardIoPkg;

	localparam int SPI_FRAME_BITS = 24; // 16 bit half period then 8 bit level
	localparam int DAC_FRAME_BITS = 16; // 4 zero control bits then 12 bit code
	localparam int DIGIT_COUNT    = 4;  // Hex digits on the display

	typedef logic [6:0] segmentT; // gfedcba, active low

	// Hex 0 to F
	localparam segmentT SEGMENT_PATTERN [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0E
	};

endpackage

//--- source/dacSpiTransmitter.sv
//--------------------------------------------------------------------------
// DAC output
// Adds and saturates the two tones, scales to a 12 bit code and
// shifts it out as a 16 bit SYNC framed SPI word
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module dacSpiTransmitter #(
	parameter int SCLK_DIVIDE = 8
) (
	input  logic             clock50Mhz,
	input  logic             reset,
	input  logic             sampleTick,
	input  audioPkg::sampleT keyAudio,
	input  audioPkg::sampleT remoteAudio,
	output logic             dacSclk,
	output logic             dacSyncN,  // Low for the whole word
	output logic             dacDin
);

	localparam int FRAME_BITS  = boardIoPkg::DAC_FRAME_BITS;
	localparam int HALF_WIDTH  = $clog2(SCLK_DIVIDE + 1);
	localparam int BIT_WIDTH   = $clog2(FRAME_BITS);

	logic [8:0]              mixSum;       // One carry bit
	audioPkg::sampleT        mixSaturated;
	audioPkg::dacCodeT       dacCode;
	logic [FRAME_BITS-1:0]   dacWord;
	logic [FRAME_BITS-1:0]   wordShift;    // Bits still to send, MSB next
	logic [HALF_WIDTH-1:0]   halfCount;    // Clocks into the current SCLK half
	logic [BIT_WIDTH-1:0]    bitCount;     // Bit now on dacDin

	// ----------------------------------------------------------------------
	// Mixer
	// ----------------------------------------------------------------------
	assign mixSum       = {1'b0, keyAudio} + {1'b0, remoteAudio};
	assign mixSaturated = mixSum[8] ? 8'hFF : mixSum[7:0];         // Clip at 255
	assign dacCode      = audioPkg::dacCodeT'(mixSaturated) << audioPkg::DAC_SHIFT;
	assign dacWord      = FRAME_BITS'(dacCode);                    // Control bits zero

	// ----------------------------------------------------------------------
	// Serializer
	// ----------------------------------------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			dacSyncN  <= 1'b1;
			dacSclk   <= 1'b0;
			dacDin    <= 1'b0;
			halfCount <= '0;
			bitCount  <= '0;
		end else if (dacSyncN) begin
			if (sampleTick) begin // Idle, start a word
				dacSyncN  <= 1'b0;
				dacSclk   <= 1'b1;
				dacDin    <= dacWord[FRAME_BITS-1];
				halfCount <= '0;
				bitCount  <= '0;
			end
		end else if (halfCount == HALF_WIDTH'(SCLK_DIVIDE - 1)) begin
			halfCount <= '0;
			if (dacSclk) begin
				dacSclk <= 1'b0; // DAC samples on this edge
			end else if (bitCount == BIT_WIDTH'(FRAME_BITS - 1)) begin
				dacSyncN <= 1'b1; // Last bit done
				dacDin   <= 1'b0;
			end else begin
				dacSclk  <= 1'b1;
				dacDin   <= wordShift[FRAME_BITS-1];
				bitCount <= bitCount + 1'b1;
			end
		end else begin
			halfCount <= halfCount + 1'b1;
		end
	end

	// Payload shifter, moves one bit per SCLK rise
	always_ff @(posedge clock50Mhz) begin
		if (dacSyncN && sampleTick) begin
			wordShift <= {dacWord[FRAME_BITS-2:0], 1'b0};
		end else if (!dacSyncN && !dacSclk && halfCount == HALF_WIDTH'(SCLK_DIVIDE - 1)) begin
			wordShift <= {wordShift[FRAME_BITS-2:0], 1'b0};
		end
	end

endmodule

//--- source/keyPanel.sv
//--------------------------------------------------------------------------
// Music key panel
// Two flop synchronizer and tick based debouncer per key,
// lowest pressed key picks the note half period
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module keyPanel #(
	parameter int DEBOUNCE_COUNT = 2
) (
	input  logic                              clock50Mhz,
	input  logic                              reset,
	input  logic                              debounceTick,
	input  logic [audioPkg::KEY_COUNT-1:0]    musicKeys,     // Active high
	output audioPkg::halfPeriodT              keyHalfPeriod
);

	localparam int KEYS        = audioPkg::KEY_COUNT;
	localparam int COUNT_WIDTH = $clog2(DEBOUNCE_COUNT + 1);

	logic [KEYS-1:0]        keySync [2];          // Synchronizer stages
	logic [KEYS-1:0]        keyState;             // Debounced level
	logic [COUNT_WIDTH-1:0] stableCount [KEYS];   // Ticks the raw level has differed
	audioPkg::halfPeriodT   noteSelect;

	// ----------------------------------------------------------------------
	// Synchronize and debounce
	// ----------------------------------------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			keySync[0] <= '0;
			keySync[1] <= '0;
			keyState   <= '0;
			for (int i = 0; i < KEYS; i++) begin
				stableCount[i] <= '0;
			end
		end else begin
			keySync[0] <= musicKeys;
			keySync[1] <= keySync[0];
			if (debounceTick) begin
				for (int i = 0; i < KEYS; i++) begin
					if (keySync[1][i] == keyState[i]) begin
						stableCount[i] <= '0; // Agrees again, start over
					end else if (stableCount[i] == COUNT_WIDTH'(DEBOUNCE_COUNT - 1)) begin
						keyState[i]    <= keySync[1][i]; // Held long enough
						stableCount[i] <= '0;
					end else begin
						stableCount[i] <= stableCount[i] + 1'b1;
					end
				end
			end
		end
	end

	// Priority encoder, lowest index wins
	always_comb begin
		noteSelect = '0;
		for (int i = KEYS - 1; i >= 0; i--) begin
			if (keyState[i]) begin
				noteSelect = audioPkg::NOTE_HALF_PERIOD[i];
			end
		end
	end

	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			keyHalfPeriod <= '0;
		end else begin
			keyHalfPeriod <= noteSelect; // Zero with no key held
		end
	end

endmodule

//--- source/musicBoxTop.sv
//--------------------------------------------------------------------------
// Music box top level
// Tick generators, key panel, Arduino receiver, two tone oscillators,
// DAC transmitter and the half period display
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module musicBoxTop #(
	parameter int SAMPLE_DIVIDE   = 1562,  // 32 kHz sample rate
	parameter int DEBOUNCE_DIVIDE = 50000, // 1 ms debounce tick
	parameter int DEBOUNCE_COUNT  = 8,
	parameter int SCLK_DIVIDE     = 2
) (
	input  logic                                               clock50Mhz,
	input  logic                                               reset,
	input  logic [audioPkg::KEY_COUNT-1:0]                     musicKeys,
	input  logic                                               spiSclk,  // From the Arduino
	input  logic                                               spiCsN,
	input  logic                                               spiSdo,
	output logic                                               dacSclk,  // To the DAC
	output logic                                               dacSyncN,
	output logic                                               dacDin,
	output boardIoPkg::segmentT [boardIoPkg::DIGIT_COUNT-1:0] segments
);

	logic                 sampleTick;
	logic                 debounceTick;
	audioPkg::halfPeriodT keyHalfPeriod;
	audioPkg::halfPeriodT remoteHalfPeriod;
	audioPkg::sampleT     remoteLevel;
	audioPkg::sampleT     keyAudio;
	audioPkg::sampleT     remoteAudio;

	// ----------------------------------------------------------------------
	// Enable ticks
	// ----------------------------------------------------------------------
	tickGenerator #(.DIVIDE(SAMPLE_DIVIDE)) sampleTicker (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.tick       (sampleTick)
	);

	tickGenerator #(.DIVIDE(DEBOUNCE_DIVIDE)) debounceTicker (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.tick       (debounceTick)
	);

	// ----------------------------------------------------------------------
	// Tone sources
	// ----------------------------------------------------------------------
	keyPanel #(.DEBOUNCE_COUNT(DEBOUNCE_COUNT)) keyPanel (
		.clock50Mhz    (clock50Mhz),
		.reset         (reset),
		.debounceTick  (debounceTick),
		.musicKeys     (musicKeys),
		.keyHalfPeriod (keyHalfPeriod)
	);

	arduinoSpiReceiver arduinoSpiReceiver (
		.clock50Mhz       (clock50Mhz),
		.reset            (reset),
		.spiSclk          (spiSclk),
		.spiCsN           (spiCsN),
		.spiSdo           (spiSdo),
		.remoteHalfPeriod (remoteHalfPeriod),
		.remoteLevel      (remoteLevel)
	);

	toneOscillator keyOscillator (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.sampleTick (sampleTick),
		.halfPeriod (keyHalfPeriod),
		.level      (audioPkg::KEY_LEVEL), // Fixed key volume
		.audio      (keyAudio)
	);

	toneOscillator remoteOscillator (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.sampleTick (sampleTick),
		.halfPeriod (remoteHalfPeriod),
		.level      (remoteLevel),
		.audio      (remoteAudio)
	);

	// ----------------------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------------------
	dacSpiTransmitter #(.SCLK_DIVIDE(SCLK_DIVIDE)) dacSpiTransmitter (
		.clock50Mhz  (clock50Mhz),
		.reset       (reset),
		.sampleTick  (sampleTick),
		.keyAudio    (keyAudio),
		.remoteAudio (remoteAudio),
		.dacSclk     (dacSclk),
		.dacSyncN    (dacSyncN),
		.dacDin      (dacDin)
	);

	segmentDisplay segmentDisplay (
		.clock50Mhz (clock50Mhz),
		.reset      (reset),
		.value      (remoteHalfPeriod), // Remote half period in hex
		.segments   (segments)
	);

endmodule

//--- source/segmentDisplay.sv
//--------------------------------------------------------------------------
// Seven segment display
// Registered hex decode of four nibbles, digit 0 least significant
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module segmentDisplay (
	input  logic                                               clock50Mhz,
	input  logic                                               reset,
	input  audioPkg::halfPeriodT                               value,
	output boardIoPkg::segmentT [boardIoPkg::DIGIT_COUNT-1:0] segments
);

	localparam int DIGITS = boardIoPkg::DIGIT_COUNT;

	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			for (int i = 0; i < DIGITS; i++) begin
				segments[i] <= boardIoPkg::SEGMENT_PATTERN[0]; // Shows 0000
			end
		end else begin
			for (int i = 0; i < DIGITS; i++) begin
				segments[i] <= boardIoPkg::SEGMENT_PATTERN[value[4*i +: 4]];
			end
		end
	end

endmodule

//--- source/tickGenerator.sv
//--------------------------------------------------------------------------
// Enable tick generator
// One cycle strobe every DIVIDE clocks, replaces a divided clock
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tickGenerator #(
	parameter int DIVIDE = 1562
) (
	input  logic clock50Mhz,
	input  logic reset,
	output logic tick
);

	localparam int WIDTH = $clog2(DIVIDE + 1); // Holds DIVIDE - 1, at least 1 bit

	logic [WIDTH-1:0] count; // Clocks left until the next strobe

	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			count <= WIDTH'(DIVIDE - 1);
			tick  <= 1'b0;
		end else if (count == '0) begin
			count <= WIDTH'(DIVIDE - 1); // Reload for the next period
			tick  <= 1'b1;
		end else begin
			count <= count - 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

//--- source/toneOscillator.sv
//--------------------------------------------------------------------------
// Square wave tone oscillator
// Half period counted in sample ticks, output height set by level
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module toneOscillator (
	input  logic                 clock50Mhz,
	input  logic                 reset,
	input  logic                 sampleTick,
	input  audioPkg::halfPeriodT halfPeriod, // 0 silences the tone
	input  audioPkg::sampleT     level,
	output audioPkg::sampleT     audio
);

	audioPkg::halfPeriodT tickCount; // Ticks into the current half wave
	logic                 phase;     // High half of the wave
	logic                 nextPhase;
	logic                 halfDone;

	assign halfDone  = (halfPeriod != '0) && (tickCount >= halfPeriod - 16'd1);
	assign nextPhase = (halfPeriod == '0) ? 1'b0 : (phase ^ halfDone);

	always_ff @(posedge clock50Mhz) begin
		if (reset) begin
			tickCount <= '0;
			phase     <= 1'b0;
			audio     <= '0;
		end else if (sampleTick) begin
			if (halfPeriod == '0 || halfDone) begin
				tickCount <= '0; // Silent or end of a half wave
			end else begin
				tickCount <= tickCount + 16'd1;
			end
			phase <= nextPhase;
			audio <= nextPhase ? level : '0; // Level only picked up on a tick
		end
	end

endmodule

//--- vlog.f
source/audioPkg.sv
source/boardIoPkg.sv
source/tickGenerator.sv
source/keyPanel.sv
source/toneOscillator.sv
source/arduinoSpiReceiver.sv
source/dacSpiTransmitter.sv
source/segmentDisplay.sv
source/musicBoxTop.sv
dv/musicBox_sva.sv
dv/musicBoxTb.sv
